//--- logic/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// word size in bits
`define MEM_DATA_W 32

// byte address into the 256-byte data memory
`define MEM_ADDR_W 8

// one bank per byte of the word
`define MEM_LANES 4

// low address bits that pick the lane
`define MEM_LANE_SEL_W $clog2(`MEM_LANES)

// word index into each bank
`define MEM_WORD_IDX_W (`MEM_ADDR_W - `MEM_LANE_SEL_W)

// entries per bank
`define MEM_BANK_DEPTH (1 << `MEM_WORD_IDX_W)

`endif

//--- logic/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    // access width carried by loads and stores
    typedef enum logic [1:0] {
        acc_byte = 2'd0,
        acc_half = 2'd1,
        acc_word = 2'd2,
        acc_rsvd = 2'd3     // reserved width writes nothing and loads zero
    } access_width_e;

    // control consumed by the memory stage
    typedef struct packed {
        logic          mem_read;   // load
        logic          mem_write;  // store
        access_width_e width;
        logic          sign_flag;  // 1 = sign-extend loads
    } mem_ctrl_t;

    // control forwarded to write-back
    typedef struct packed {
        logic reg_write;  // result goes to the register file
        logic mem2reg;    // pick memory data over the ALU result
    } wb_ctrl_t;

endpackage

`default_nettype wire

//--- logic/mem_bus_pkg.sv
`default_nettype none

`include "mem_stage_cfg.svh"

package mem_bus_pkg;

    // EX/MEM pipeline register contents
    typedef struct packed {
        logic [`MEM_DATA_W-1:0]  alu_result;  // also the memory address
        logic [`MEM_DATA_W-1:0]  store_data;
        logic [4:0]              rd;          // destination register
        mips_ctrl_pkg::mem_ctrl_t mem;
        mips_ctrl_pkg::wb_ctrl_t  wb;
    } ex_mem_t;

    // MEM/WB pipeline register contents
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rd_data;     // loaded value
        logic [`MEM_DATA_W-1:0] alu_result;
        logic [4:0]             rd;
        mips_ctrl_pkg::wb_ctrl_t wb;
    } mem_wb_t;

    // write request for one byte lane
    typedef struct packed {
        logic                       wr_en;
        logic [`MEM_WORD_IDX_W-1:0] idx;    // word index shared by all lanes
        logic [7:0]                 data;
    } lane_write_t;

endpackage

`default_nettype wire

//--- logic/store_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module store_aligner (
    input  wire  [`MEM_ADDR_W-1:0]      i_addr,
    input  wire  [`MEM_DATA_W-1:0]      i_data,
    input  wire  mips_ctrl_pkg::mem_ctrl_t i_ctrl,
    input  wire                         i_wr_allow,
    output mem_bus_pkg::lane_write_t    o_lane [0:`MEM_LANES-1]
);

    logic [`MEM_LANES-1:0]  lane_en;    // byte enables before gating
    logic [`MEM_DATA_W-1:0] lane_data;  // store data spread over the lanes
    logic                   wr_ok;

    assign wr_ok = i_ctrl.mem_write & i_wr_allow;

    always_comb begin
        lane_en   = '0;
        lane_data = '0;
        case (i_ctrl.width)
            mips_ctrl_pkg::acc_byte: begin
                lane_en[i_addr[`MEM_LANE_SEL_W-1:0]] = 1'b1;  // one lane by bits 1:0
                lane_data = {4{i_data[7:0]}};
            end
            mips_ctrl_pkg::acc_half: begin
                // bit 1 picks the upper or lower pair and bit 0 is ignored
                lane_en   = i_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_data[15:0]}};                 // little-endian halves
            end
            mips_ctrl_pkg::acc_word: begin
                lane_en   = '1;
                lane_data = i_data;
            end
            default: begin
                lane_en   = '0;                                // reserved width
                lane_data = '0;
            end
        endcase
        if (!wr_ok) begin
            lane_en = '0;                                      // no store or frozen
        end
    end

    always_comb begin
        for (int l = 0; l < `MEM_LANES; l++) begin
            o_lane[l].wr_en = lane_en[l];
            o_lane[l].idx   = i_addr[`MEM_ADDR_W-1:`MEM_LANE_SEL_W];
            o_lane[l].data  = lane_data[8*l +: 8];
        end
    end

endmodule

`default_nettype wire

//--- logic/byte_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module byte_bank (
    input  wire                         clk,
    input  wire mem_bus_pkg::lane_write_t i_wr,
    output logic [7:0]                  o_rd_byte
);

    logic [7:0] mem [0:`MEM_BANK_DEPTH-1];  // one byte per word index

    // synchronous write
    always_ff @(posedge clk) begin
        if (i_wr.wr_en) begin
            mem[i_wr.idx] <= i_wr.data;
        end
    end

    // read is asynchronous, so a load sees the byte in the same cycle
    assign o_rd_byte = mem[i_wr.idx];

endmodule

`default_nettype wire

//--- logic/load_extractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module load_extractor (
    input  wire  [7:0]                  i_lane_bytes [0:`MEM_LANES-1],
    input  wire  [`MEM_LANE_SEL_W-1:0]  i_addr_lo,
    input  wire  mips_ctrl_pkg::mem_ctrl_t i_ctrl,
    output logic [`MEM_DATA_W-1:0]      o_load
);

    logic [`MEM_DATA_W-1:0] word;      // lanes reassembled little-endian
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;
    logic                   byte_msb;  // extension bit for byte loads
    logic                   half_msb;  // extension bit for half loads

    always_comb begin
        for (int l = 0; l < `MEM_LANES; l++) begin
            word[8*l +: 8] = i_lane_bytes[l];
        end
    end

    assign sel_byte = i_lane_bytes[i_addr_lo];               // bits 1:0 pick the lane
    assign sel_half = i_addr_lo[1] ? word[31:16] : word[15:0];  // bit 0 ignored

    assign byte_msb = i_ctrl.sign_flag & sel_byte[7];
    assign half_msb = i_ctrl.sign_flag & sel_half[15];

    always_comb begin
        case (i_ctrl.width)
            mips_ctrl_pkg::acc_byte: begin
                o_load = {{24{byte_msb}}, sel_byte};
            end
            mips_ctrl_pkg::acc_half: begin
                o_load = {{16{half_msb}}, sel_half};
            end
            mips_ctrl_pkg::acc_word: begin
                o_load = word;
            end
            default: begin
                o_load = '0;                                 // reserved width
            end
        endcase
        if (!i_ctrl.mem_read) begin
            o_load = '0;                                     // not a load
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage (
    input  wire                    clk,
    input  wire                    i_rst_n,
    input  wire                    i_stall,
    input  wire                    i_halt,
    input  wire mem_bus_pkg::ex_mem_t i_ex,
    output mem_bus_pkg::mem_wb_t   o_wb
);

    logic                     wr_allow;   // low freezes the stage
    logic [`MEM_ADDR_W-1:0]   addr;
    mem_bus_pkg::lane_write_t lane_wr [0:`MEM_LANES-1];
    logic [7:0]               lane_rd [0:`MEM_LANES-1];
    logic [`MEM_DATA_W-1:0]   load_data;
    mem_bus_pkg::mem_wb_t     wb_next;

    assign wr_allow = ~(i_stall | i_halt);
    assign addr     = i_ex.alu_result[`MEM_ADDR_W-1:0];  // upper bits unused for memory

    store_aligner u_aligner (
        .i_addr     (addr),
        .i_data     (i_ex.store_data),
        .i_ctrl     (i_ex.mem),
        .i_wr_allow (wr_allow),
        .o_lane     (lane_wr)
    );

    // one byte-wide bank per lane
    generate
        for (genvar l = 0; l < `MEM_LANES; l++) begin : g_lane
            byte_bank u_bank (
                .clk       (clk),
                .i_wr      (lane_wr[l]),
                .o_rd_byte (lane_rd[l])
            );
        end
    endgenerate

    load_extractor u_extract (
        .i_lane_bytes (lane_rd),
        .i_addr_lo    (addr[`MEM_LANE_SEL_W-1:0]),
        .i_ctrl       (i_ex.mem),
        .o_load       (load_data)
    );

    always_comb begin
        wb_next.rd_data    = load_data;
        wb_next.alu_result = i_ex.alu_result;
        wb_next.rd         = i_ex.rd;
        wb_next.wb         = i_ex.wb;
    end

    // MEM/WB register holds while stalled or halted
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb <= '0;                       // reg_write and mem2reg inactive
        end else if (wr_allow) begin
            o_wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

//--- bench/mem_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_properties (
    input wire                           clk,
    input wire                           i_rst_n,
    input wire                           i_stall,
    input wire                           i_halt,
    input wire mem_bus_pkg::mem_wb_t     i_wb,
    input wire mem_bus_pkg::lane_write_t i_lane_wr [0:`MEM_LANES-1]
);

    logic                  frozen;            // stall or halt
    logic [`MEM_LANES-1:0] lane_en;
    int                    n_reset_fail = 0;
    int                    n_hold_fail  = 0;
    int                    n_lane_fail  = 0;

    assign frozen = i_stall | i_halt;

    always_comb begin
        for (int l = 0; l < `MEM_LANES; l++) begin
            lane_en[l] = i_lane_wr[l].wr_en;
        end
    end

    // the clear is asynchronous so every edge inside reset sees zero
    wb_clear_in_reset: assert property (@(posedge clk) !i_rst_n |-> i_wb.wb == '0)
    else begin
        $error("write-back control is not zero during reset");
        n_reset_fail++;
    end

    wb_hold_when_frozen: assert property (@(posedge clk) disable iff (!i_rst_n)
        frozen |=> $stable(i_wb))
    else begin
        $error("MEM/WB register changed after a stalled or halted cycle");
        n_hold_fail++;
    end

    no_write_when_frozen: assert property (@(posedge clk) disable iff (!i_rst_n)
        frozen |-> lane_en == '0)
    else begin
        $error("lane write enable high while stalled or halted");
        n_lane_fail++;
    end

endmodule

`default_nettype wire

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int MAX_CYCLES = 600;            // about twice the whole sequence
    localparam int MEM_BYTES  = 1 << `MEM_ADDR_W;
    localparam int RAND_OPS   = 100;

    logic                 clk = 1'b0;
    logic                 i_rst_n;
    logic                 i_stall;
    logic                 i_halt;
    mem_bus_pkg::ex_mem_t i_ex;
    mem_bus_pkg::mem_wb_t o_wb;

    logic [7:0]           ref_mem [0:MEM_BYTES-1];  // byte-addressed model
    mem_bus_pkg::mem_wb_t exp_wb;                   // expected MEM/WB contents
    logic [31:0]          lcg_state;
    int                   errors;
    int                   prop_fails;
    int                   cycles = 0;

    mem_stage uut (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_stall (i_stall),
        .i_halt  (i_halt),
        .i_ex    (i_ex),
        .o_wb    (o_wb)
    );

    bind mem_stage mem_stage_properties u_props (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (i_stall),
        .i_halt    (i_halt),
        .i_wb      (o_wb),
        .i_lane_wr (lane_wr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // every byte differs with its full address
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a + 8'd3, a + 8'd2, a + 8'd1, a} ^ 32'h3c5a_96e1;
    endfunction

    function automatic mem_bus_pkg::ex_mem_t make_ex(
        input logic [31:0]                  alu,
        input logic [31:0]                  sdata,
        input logic [4:0]                   rd,
        input logic                         rd_en,
        input logic                         wr_en,
        input mips_ctrl_pkg::access_width_e width,
        input logic                         sgn
    );
        mem_bus_pkg::ex_mem_t ex;
        ex.alu_result    = alu;
        ex.store_data    = sdata;
        ex.rd            = rd;
        ex.mem.mem_read  = rd_en;
        ex.mem.mem_write = wr_en;
        ex.mem.width     = width;
        ex.mem.sign_flag = sgn;
        ex.wb.reg_write  = rd_en;  // loads write memory data back
        ex.wb.mem2reg    = rd_en;
        return ex;
    endfunction

    function automatic logic [31:0] model_load(input logic [7:0] addr,
                                               input mips_ctrl_pkg::mem_ctrl_t ctrl);
        logic [7:0]  base;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [31:0] val;
        val = '0;
        if (!ctrl.mem_read) begin
            return val;
        end
        case (ctrl.width)
            mips_ctrl_pkg::acc_byte: begin
                lo  = ref_mem[addr];
                val = ctrl.sign_flag ? {{24{lo[7]}}, lo} : {24'h0, lo};
            end
            mips_ctrl_pkg::acc_half: begin
                base = {addr[7:1], 1'b0};            // bit 0 has no effect
                lo   = ref_mem[base];
                hi   = ref_mem[base + 8'd1];
                val  = ctrl.sign_flag ? {{16{hi[7]}}, hi, lo} : {16'h0, hi, lo};
            end
            mips_ctrl_pkg::acc_word: begin
                base = {addr[7:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    val[8*k +: 8] = ref_mem[base + 8'(k)];
                end
            end
            default: val = '0;                       // reserved loads zero
        endcase
        return val;
    endfunction

    task automatic model_store(input logic [7:0] addr, input logic [31:0] data,
                               input mips_ctrl_pkg::mem_ctrl_t ctrl);
        logic [7:0] base;
        if (!ctrl.mem_write) begin
            return;
        end
        case (ctrl.width)
            mips_ctrl_pkg::acc_byte: begin
                ref_mem[addr] = data[7:0];
            end
            mips_ctrl_pkg::acc_half: begin
                base                 = {addr[7:1], 1'b0};
                ref_mem[base]        = data[7:0];
                ref_mem[base + 8'd1] = data[15:8];
            end
            mips_ctrl_pkg::acc_word: begin
                base = {addr[7:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    ref_mem[base + 8'(k)] = data[8*k +: 8];
                end
            end
            default: ;                               // reserved writes nothing
        endcase
    endtask

    task automatic check_word(input string name, input logic [`MEM_DATA_W-1:0] exp,
                              input logic [`MEM_DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_wb_ctrl(input string name, input mips_ctrl_pkg::wb_ctrl_t exp,
                                 input mips_ctrl_pkg::wb_ctrl_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_word("o_wb.rd_data", exp_wb.rd_data, o_wb.rd_data);
        check_word("o_wb.alu_result", exp_wb.alu_result, o_wb.alu_result);
        check_reg("o_wb.rd", exp_wb.rd, o_wb.rd);
        check_wb_ctrl("o_wb.wb", exp_wb.wb, o_wb.wb);
    endtask

    // called on a falling edge and returns on the next one
    task automatic do_access(input mem_bus_pkg::ex_mem_t ex, input logic stall,
                             input logic halt);
        logic [7:0] addr;
        addr    = ex.alu_result[7:0];
        i_ex    = ex;
        i_stall = stall;
        i_halt  = halt;
        if (!(stall || halt)) begin
            exp_wb.rd_data    = model_load(addr, ex.mem);  // read sees the old contents
            exp_wb.alu_result = ex.alu_result;
            exp_wb.rd         = ex.rd;
            exp_wb.wb         = ex.wb;
            model_store(addr, ex.store_data, ex.mem);
        end
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic test_reset();
        mem_bus_pkg::ex_mem_t ex;
        ex    = make_ex(32'h0000_a5c3, 32'h0, 5'd17, 1'b0, 1'b0,
                        mips_ctrl_pkg::acc_word, 1'b0);
        ex.wb = '1;                                   // nonzero fields held off by reset
        @(negedge clk);
        i_rst_n = 1'b0;
        i_ex    = ex;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs();                              // still in reset
        i_rst_n = 1'b1;
        do_access('0, 1'b0, 1'b0);
    endtask

    task automatic fill_memory();
        logic [7:0] a;
        for (int w = 0; w < `MEM_BANK_DEPTH; w++) begin
            a = 8'(w * `MEM_LANES);
            do_access(make_ex({24'h0, a}, fill_word(a), 5'd0, 1'b0, 1'b1,
                              mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        end
    endtask

    task automatic test_word_roundtrip();
        mem_bus_pkg::ex_mem_t ex;
        do_access(make_ex(32'h1234_5640, 32'hdead_beef, 5'd7, 1'b0, 1'b1,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        do_access(make_ex(32'h8765_4340, 32'h0, 5'd12, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        ex = make_ex(32'hcafe_f00d, 32'h0, 5'd19, 1'b0, 1'b0, mips_ctrl_pkg::acc_word, 1'b0);
        ex.wb.reg_write = 1'b1;                       // plain ALU result passing through
        do_access(ex, 1'b0, 1'b0);
    endtask

    task automatic test_partial_stores();
        for (int off = 0; off < 4; off++) begin
            do_access(make_ex(32'h80 + 32'(off), 32'h55aa_0010 + 32'(off), 5'd0, 1'b0, 1'b1,
                              mips_ctrl_pkg::acc_byte, 1'b0), 1'b0, 1'b0);
            do_access(make_ex(32'h80, 32'h0, 5'd3, 1'b1, 1'b0,
                              mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        end
        for (int off = 0; off < 4; off++) begin
            do_access(make_ex(32'h90 + 32'(off), 32'h7700_c3c0 + 32'(off), 5'd0, 1'b0, 1'b1,
                              mips_ctrl_pkg::acc_half, 1'b0), 1'b0, 1'b0);
            do_access(make_ex(32'h90, 32'h0, 5'd4, 1'b1, 1'b0,
                              mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        end
    endtask

    task automatic test_load_extension();
        do_access(make_ex(32'ha0, 32'h80ff_7f81, 5'd0, 1'b0, 1'b1,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        for (int off = 0; off < 4; off++) begin
            for (int s = 0; s < 2; s++) begin
                do_access(make_ex(32'ha0 + 32'(off), 32'h0, 5'd9, 1'b1, 1'b0,
                                  mips_ctrl_pkg::acc_byte, s[0]), 1'b0, 1'b0);
                do_access(make_ex(32'ha0 + 32'(off), 32'h0, 5'd10, 1'b1, 1'b0,
                                  mips_ctrl_pkg::acc_half, s[0]), 1'b0, 1'b0);
            end
        end
        do_access(make_ex(32'ha0, 32'h1111_1111, 5'd0, 1'b0, 1'b1,
                          mips_ctrl_pkg::acc_rsvd, 1'b0), 1'b0, 1'b0);
        do_access(make_ex(32'ha0, 32'h0, 5'd11, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_rsvd, 1'b1), 1'b0, 1'b0);
        do_access(make_ex(32'ha0, 32'h0, 5'd11, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
    endtask

    task automatic test_freeze(input logic use_halt);
        do_access(make_ex(32'hb0, 32'h0, 5'd21, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
        do_access(make_ex(32'hb0, 32'h0bad_f00d, 5'd22, 1'b0, 1'b1,
                          mips_ctrl_pkg::acc_word, 1'b0), !use_halt, use_halt);
        do_access(make_ex(32'hb1, 32'h0, 5'd23, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_byte, 1'b1), !use_halt, use_halt);
        do_access(make_ex(32'hb0, 32'h0, 5'd24, 1'b1, 1'b0,
                          mips_ctrl_pkg::acc_word, 1'b0), 1'b0, 1'b0);
    endtask

    task automatic test_random();
        logic [31:0]          r;
        logic [31:0]          data;
        logic [31:0]          hi;
        mem_bus_pkg::ex_mem_t ex;
        for (int n = 0; n < RAND_OPS; n++) begin
            r    = next_rand();
            data = next_rand();
            hi   = next_rand();
            // fields come from the upper LCG bits where the period is long
            ex = make_ex({hi[31:8], r[31:24]}, data, r[12:8], r[20], r[19],
                         mips_ctrl_pkg::access_width_e'(r[23:22]), r[21]);
            do_access(ex, r[18:16] == 3'd0, r[15:13] == 3'd0);
        end
    endtask

    initial begin
        errors     = 0;
        prop_fails = 0;
        lcg_state  = 32'h84c9;
        exp_wb     = '0;
        i_rst_n    = 1'b1;
        i_stall    = 1'b0;
        i_halt     = 1'b0;
        i_ex       = '0;

        test_reset();
        fill_memory();
        test_word_roundtrip();
        test_partial_stores();
        test_load_extension();
        test_freeze(1'b0);     // stall
        test_freeze(1'b1);     // halt
        test_random();

        prop_fails = uut.u_props.n_reset_fail + uut.u_props.n_hold_fail
                   + uut.u_props.n_lane_fail;
        $display("end of run: %0d mismatches, %0d assertion failures", errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/mips_ctrl_pkg.sv
logic/mem_bus_pkg.sv
logic/store_aligner.sv
logic/byte_bank.sv
logic/load_extractor.sv
logic/mem_stage.sv
bench/mem_stage_properties.sv
bench/mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the memory stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mem_stage_sim
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_stage_tb -Mdir "$build_dir" -o "$sim_bin" -f sources.f
if [ $? -ne 0 ]; then
    echo "error: verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report it
"./$build_dir/$sim_bin" +verilator+error+limit+100 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "error: simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test passed" "$log_file"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail, see $log_file"
exit 1
